/* compile.f */
+incdir+sim
hw/ipu_pkg.sv
hw/ipu_decoder.sv
hw/ipu_regfile.sv
hw/ipu_execute.sv
hw/ipu_int_ss.sv
sim/tb_clock_gen.sv
sim/tb_ipu_int_ss.sv

/* Bender.yml */
package:
  name: ipu_int_ss

sources:
  - files:
      - hw/ipu_pkg.sv
      - hw/ipu_decoder.sv
      - hw/ipu_regfile.sv
      - hw/ipu_execute.sv
      - hw/ipu_int_ss.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_ipu_int_ss.sv

/* sim/tb_ipu_tasks.svh */
// Testbench helpers: value check, random numbers, instruction encoding and channel tasks.
// Included inside the testbench top after the DUT signals are declared.

`ifndef TB_IPU_TASKS_SVH
`define TB_IPU_TASKS_SVH

int unsigned error_count   = 0;
int unsigned timeout_count = 0;
logic [31:0] lcg_state     = 32'd12;
logic [4:0]  id_counter    = 5'd0;

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    error_count++;
    $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h",
             $time, name, expected, actual);
  end
endtask

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic logic [4:0] next_id();
  id_counter = id_counter + 5'd1;
  return id_counter;
endfunction

// R-type layout; I-type passes imm[11:5] and imm[4:0] as funct7 and rs2
function automatic logic [31:0] encode_instr(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

task automatic drive_request(input logic [4:0] id, input logic [31:0] instr,
                             input logic [31:0] arga, input logic [31:0] argb);
  @(negedge clk);
  acc_req_valid_i = 1'b1;
  acc_req_id_i    = id;
  acc_req_op_i    = instr;
  acc_req_arga_i  = arga;
  acc_req_argb_i  = argb;
endtask

// Returns on the falling edge after the accepting rising edge
task automatic wait_accept();
  int unsigned waited;
  logic        taken;
  waited = 0;
  taken  = 1'b0;
  while (!taken && waited < TimeoutCycles) begin
    #1;
    taken = acc_req_ready_o;
    @(negedge clk);
    waited++;
  end
  acc_req_valid_i = 1'b0;
  if (!taken) begin
    timeout_count++;
    $display("Timeout: request id %0d was never accepted", acc_req_id_i);
  end
endtask

task automatic send_request(input logic [4:0] id, input logic [31:0] instr,
                            input logic [31:0] arga, input logic [31:0] argb);
  drive_request(id, instr, arga, argb);
  wait_accept();
endtask

task automatic expect_response(input logic [4:0] id, input logic [31:0] data,
                               input logic error);
  int unsigned waited;
  waited = 0;
  while (!acc_resp_valid_o && waited < TimeoutCycles) begin
    @(negedge clk);
    waited++;
  end
  if (!acc_resp_valid_o) begin
    timeout_count++;
    $display("Timeout: no response arrived for request id %0d", id);
  end else begin
    check_value("acc_resp_id_o", id, acc_resp_id_o);
    check_value("acc_resp_data_o", data, acc_resp_data_o);
    check_value("acc_resp_error_o", error, acc_resp_error_o);
    // Ready is high, so the next rising edge takes it
    @(negedge clk);
  end
endtask

`endif

/* sim/tb_ipu_int_ss.sv */
// Testbench top for the integer subsystem.
// Directed tests over the request and response channels, then a closing report.

`timescale 1ns/1ps

module tb_ipu_int_ss;

  localparam int unsigned TimeoutCycles = 50;

  logic        clk;
  logic        rst;
  logic        acc_req_valid_i;
  logic        acc_req_ready_o;
  logic [4:0]  acc_req_id_i;
  logic [31:0] acc_req_op_i;
  logic [31:0] acc_req_arga_i;
  logic [31:0] acc_req_argb_i;
  logic        acc_resp_valid_o;
  logic        acc_resp_ready_i;
  logic [4:0]  acc_resp_id_o;
  logic [31:0] acc_resp_data_o;
  logic        acc_resp_error_o;

  tb_clock_gen i_clock_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  ipu_int_ss dut_i (
    .clk_i            ( clk              ),
    .rst_i            ( rst              ),
    .acc_req_valid_i  ( acc_req_valid_i  ),
    .acc_req_ready_o  ( acc_req_ready_o  ),
    .acc_req_id_i     ( acc_req_id_i     ),
    .acc_req_op_i     ( acc_req_op_i     ),
    .acc_req_arga_i   ( acc_req_arga_i   ),
    .acc_req_argb_i   ( acc_req_argb_i   ),
    .acc_resp_valid_o ( acc_resp_valid_o ),
    .acc_resp_ready_i ( acc_resp_ready_i ),
    .acc_resp_id_o    ( acc_resp_id_o    ),
    .acc_resp_data_o  ( acc_resp_data_o  ),
    .acc_resp_error_o ( acc_resp_error_o )
  );

  `include "tb_ipu_tasks.svh"

  // Signed compares work on sign-flipped copies
  function automatic logic [31:0] ref_alu(input string op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] sa;
    logic [31:0] sb;
    logic [4:0]  sh;
    sa = a ^ 32'h8000_0000;
    sb = b ^ 32'h8000_0000;
    sh = b[4:0];
    case (op)
      "add":   return a + b;
      "sub":   return a + ~b + 32'd1;
      "sll":   return a << sh;
      "srl":   return a >> sh;
      "sra":   return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
      "slt":   return {31'd0, sa < sb};
      "sltu":  return {31'd0, a < b};
      "and":   return a & b;
      "or":    return a | b;
      "xor":   return a ^ b;
      "andn":  return a & ~b;
      "orn":   return a | ~b;
      "xnor":  return ~(a ^ b);
      "min":   return (sa < sb) ? a : b;
      "max":   return (sa < sb) ? b : a;
      "minu":  return (a < b) ? a : b;
      "maxu":  return (a < b) ? b : a;
      default: return 32'hDEAD_BEEF;
    endcase
  endfunction

  // Response must be valid one cycle after acceptance
  task automatic request_and_check(input logic [31:0] instr, input logic [31:0] arga,
                                   input logic [31:0] argb, input logic [31:0] data,
                                   input logic error);
    logic [4:0] id;
    id = next_id();
    send_request(id, instr, arga, argb);
    check_value("acc_resp_valid_o", 32'd1, acc_resp_valid_o);
    expect_response(id, data, error);
  endtask

  task automatic write_reg(input logic [4:0] idx, input logic [31:0] value);
    send_request(next_id(), encode_instr(7'h00, 5'd0, 5'd0, 3'b001, idx,
                                         ipu_pkg::OpcIpuMove), value, 32'd0);
  endtask

  task automatic read_reg(input logic [4:0] idx, input logic [31:0] expected);
    request_and_check(encode_instr(7'h00, 5'd0, idx, 3'b000, 5'd0, ipu_pkg::OpcIpuMove),
                      32'd0, 32'd0, expected, 1'b0);
  endtask

  task automatic run_reg_op(input string op, input logic [2:0] f3, input logic [6:0] f7,
                            input logic [31:0] a, input logic [31:0] b);
    write_reg(5'd1, a);
    write_reg(5'd2, b);
    send_request(next_id(), encode_instr(f7, 5'd2, 5'd1, f3, 5'd3, ipu_pkg::OpcIpuReg),
                 32'd0, 32'd0);
    read_reg(5'd3, ref_alu(op, a, b));
  endtask

  task automatic run_imm_op(input string op, input logic [2:0] f3, input logic [11:0] imm,
                            input logic [31:0] a);
    write_reg(5'd4, a);
    send_request(next_id(), encode_instr(imm[11:5], imm[4:0], 5'd4, f3, 5'd6,
                                         ipu_pkg::OpcIpuImm), 32'd0, 32'd0);
    read_reg(5'd6, ref_alu(op, a, {{20{imm[11]}}, imm}));
  endtask

  task automatic test_moves();
    logic [31:0] vals [4];
    for (int i = 0; i < 4; i++) begin
      vals[i] = lcg_next();
      write_reg(5'd8 + i[4:0], vals[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_reg(5'd8 + i[4:0], vals[i]);
    end
  endtask

  task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    run_reg_op("add", 3'b000, 7'h00, a, b);
    run_reg_op("sub", 3'b000, 7'h20, a, b);
    run_reg_op("sll", 3'b001, 7'h00, a, b);
    run_reg_op("slt", 3'b010, 7'h00, a, b);
    run_reg_op("sltu", 3'b011, 7'h00, a, b);
    run_reg_op("xor", 3'b100, 7'h00, a, b);
    run_reg_op("srl", 3'b101, 7'h00, a, b);
    run_reg_op("sra", 3'b101, 7'h20, a | 32'h8000_0000, b);
    run_reg_op("or", 3'b110, 7'h00, a, b);
    run_reg_op("and", 3'b111, 7'h00, a, b);
    // Sign matters here
    run_reg_op("slt", 3'b010, 7'h00, 32'hFFFF_FFF0, 32'd5);
    run_reg_op("sltu", 3'b011, 7'h00, 32'hFFFF_FFF0, 32'd5);
    run_imm_op("add", 3'b000, 12'hFFD, a);
    run_imm_op("slt", 3'b010, 12'h800, a);
    run_imm_op("sltu", 3'b011, 12'hFFF, a);
    run_imm_op("xor", 3'b100, 12'h9A5, a);
    run_imm_op("or", 3'b110, 12'h0F0, a);
    run_imm_op("and", 3'b111, 12'hF0F, a);
    run_imm_op("sll", 3'b001, 12'h009, a);
    run_imm_op("srl", 3'b101, 12'h00D, a | 32'h8000_0000);
    run_imm_op("sra", 3'b101, {7'h20, 5'd7}, a | 32'h8000_0000);
  endtask

  task automatic run_bus_op(input string op, input logic [6:0] f7, input logic [2:0] f3,
                            input logic [31:0] a, input logic [31:0] b);
    request_and_check(encode_instr(f7, 5'd7, 5'd7, f3, 5'd7, ipu_pkg::OpcOp),
                      a, b, ref_alu(op, a, b), 1'b0);
  endtask

  task automatic test_bus_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] marker;
    marker = lcg_next();
    write_reg(5'd7, marker);
    for (int i = 0; i < 3; i++) begin
      a = lcg_next();
      b = lcg_next();
      run_bus_op("andn", 7'h20, 3'b111, a, b);
      run_bus_op("orn", 7'h20, 3'b110, a, b);
      run_bus_op("xnor", 7'h20, 3'b100, a, b);
      run_bus_op("min", 7'h05, 3'b100, a, b);
      run_bus_op("minu", 7'h05, 3'b101, a, b);
      run_bus_op("max", 7'h05, 3'b110, a, b);
      run_bus_op("maxu", 7'h05, 3'b111, a, b);
    end
    // Opposite signs split the signed and unsigned results
    run_bus_op("min", 7'h05, 3'b100, 32'h8000_0010, 32'h0000_0123);
    run_bus_op("minu", 7'h05, 3'b101, 32'h8000_0010, 32'h0000_0123);
    run_bus_op("max", 7'h05, 3'b110, 32'h8000_0010, 32'h0000_0123);
    run_bus_op("maxu", 7'h05, 3'b111, 32'h8000_0010, 32'h0000_0123);
    // rd of the bus ops pointed at r7
    read_reg(5'd7, marker);
  endtask

  task automatic test_illegal();
    request_and_check(32'hFFFF_FFFF, lcg_next(), lcg_next(), 32'd0, 1'b1);
    request_and_check(encode_instr(7'h00, 5'd0, 5'd1, 3'b010, 5'd0, ipu_pkg::OpcIpuMove),
                      lcg_next(), 32'd0, 32'd0, 1'b1);
    request_and_check(encode_instr(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, ipu_pkg::OpcIpuReg),
                      32'd0, 32'd0, 32'd0, 1'b1);
  endtask

  task automatic test_backpressure();
    logic [31:0] va;
    logic [31:0] vb;
    logic [4:0]  id_a;
    logic [4:0]  id_b;
    va   = lcg_next();
    vb   = lcg_next();
    id_a = next_id();
    id_b = next_id();
    write_reg(5'd12, va);
    write_reg(5'd13, vb);
    @(negedge clk);
    acc_resp_ready_i = 1'b0;
    send_request(id_a, encode_instr(7'h00, 5'd0, 5'd12, 3'b000, 5'd0, ipu_pkg::OpcIpuMove),
                 32'd0, 32'd0);
    drive_request(id_b, encode_instr(7'h00, 5'd0, 5'd13, 3'b000, 5'd0, ipu_pkg::OpcIpuMove),
                  32'd0, 32'd0);
    repeat (4) begin
      #1;
      check_value("acc_req_ready_o", 32'd0, acc_req_ready_o);
      check_value("acc_resp_valid_o", 32'd1, acc_resp_valid_o);
      check_value("acc_resp_id_o", id_a, acc_resp_id_o);
      check_value("acc_resp_data_o", va, acc_resp_data_o);
      check_value("acc_resp_error_o", 32'd0, acc_resp_error_o);
      @(negedge clk);
    end
    acc_resp_ready_i = 1'b1;
    wait_accept();
    expect_response(id_b, vb, 1'b0);
  endtask

  initial begin
    int unsigned waited;
    acc_req_valid_i  = 1'b0;
    acc_req_id_i     = '0;
    acc_req_op_i     = '0;
    acc_req_arga_i   = '0;
    acc_req_argb_i   = '0;
    acc_resp_ready_i = 1'b1;
    waited = 0;
    while (rst !== 1'b0 && waited < TimeoutCycles) begin
      @(posedge clk);
      waited++;
    end
    if (rst !== 1'b0) begin
      timeout_count++;
      $display("Timeout: reset was never released");
    end
    @(negedge clk);
    check_value("acc_resp_valid_o", 32'd0, acc_resp_valid_o);
    check_value("acc_req_ready_o", 32'd1, acc_req_ready_o);
    test_moves();
    test_alu();
    test_bus_ops();
    test_illegal();
    test_backpressure();
    $display("Summary: %0d value errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sim/tb_clock_gen.sv */
// Clock and reset source for the testbench.
// 10 ns clock, reset held high for the first 3 cycles.

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

/* hw/ipu_int_ss.sv */
// Top level of the integer subsystem.
// Takes offloaded requests, runs them on the local register file and answers.

`timescale 1ns/1ps

module ipu_int_ss (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // Request channel
  input  logic                           acc_req_valid_i,
  output logic                           acc_req_ready_o,
  input  logic [ipu_pkg::IdWidth-1:0]    acc_req_id_i,
  input  logic [ipu_pkg::InstrWidth-1:0] acc_req_op_i,
  input  logic [ipu_pkg::DataWidth-1:0]  acc_req_arga_i,
  input  logic [ipu_pkg::DataWidth-1:0]  acc_req_argb_i,
  // Response channel
  output logic                           acc_resp_valid_o,
  input  logic                           acc_resp_ready_i,
  output logic [ipu_pkg::IdWidth-1:0]    acc_resp_id_o,
  output logic [ipu_pkg::DataWidth-1:0]  acc_resp_data_o,
  output logic                           acc_resp_error_o
);

  logic [ipu_pkg::RegAddrWidth-1:0] rs1;
  logic [ipu_pkg::RegAddrWidth-1:0] rs2;
  logic [ipu_pkg::DataWidth-1:0]    rs_a;
  logic [ipu_pkg::DataWidth-1:0]    rs_b;

  ipu_pkg::alu_op_e alu_op;
  ipu_pkg::op_sel_e op_sel_a;
  ipu_pkg::op_sel_e op_sel_b;
  logic             res_to_bus;
  logic             writes_reg;
  logic             illegal;

  logic                             rf_we;
  logic [ipu_pkg::RegAddrWidth-1:0] rf_waddr;
  logic [ipu_pkg::DataWidth-1:0]    rf_wdata;

  assign rs1 = acc_req_op_i[ipu_pkg::Rs1Msb:ipu_pkg::Rs1Lsb];
  assign rs2 = acc_req_op_i[ipu_pkg::Rs2Msb:ipu_pkg::Rs2Lsb];

  ipu_decoder i_decoder (
    .instr_i      ( acc_req_op_i ),
    .alu_op_o     ( alu_op       ),
    .op_sel_a_o   ( op_sel_a     ),
    .op_sel_b_o   ( op_sel_b     ),
    .res_to_bus_o ( res_to_bus   ),
    .writes_reg_o ( writes_reg   ),
    .illegal_o    ( illegal      )
  );

  ipu_regfile i_regfile (
    .clk_i     ( clk_i    ),
    .raddr_a_i ( rs1      ),
    .raddr_b_i ( rs2      ),
    .rdata_a_o ( rs_a     ),
    .rdata_b_o ( rs_b     ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata )
  );

  ipu_execute i_execute (
    .clk_i        ( clk_i            ),
    .rst_i        ( rst_i            ),
    .req_valid_i  ( acc_req_valid_i  ),
    .req_ready_o  ( acc_req_ready_o  ),
    .req_id_i     ( acc_req_id_i     ),
    .req_instr_i  ( acc_req_op_i     ),
    .req_arga_i   ( acc_req_arga_i   ),
    .req_argb_i   ( acc_req_argb_i   ),
    .alu_op_i     ( alu_op           ),
    .op_sel_a_i   ( op_sel_a         ),
    .op_sel_b_i   ( op_sel_b         ),
    .res_to_bus_i ( res_to_bus       ),
    .writes_reg_i ( writes_reg       ),
    .illegal_i    ( illegal          ),
    .rs_a_i       ( rs_a             ),
    .rs_b_i       ( rs_b             ),
    .rf_we_o      ( rf_we            ),
    .rf_waddr_o   ( rf_waddr         ),
    .rf_wdata_o   ( rf_wdata         ),
    .resp_valid_o ( acc_resp_valid_o ),
    .resp_ready_i ( acc_resp_ready_i ),
    .resp_id_o    ( acc_resp_id_o    ),
    .resp_data_o  ( acc_resp_data_o  ),
    .resp_error_o ( acc_resp_error_o )
  );

endmodule

/* hw/ipu_execute.sv */
// Execute stage: operand muxing, ALU, register write-back and both handshakes.
// Responses are held in a one-deep register until the core takes them.

`timescale 1ns/1ps

module ipu_execute (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Request
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic [ipu_pkg::IdWidth-1:0]      req_id_i,
  input  logic [ipu_pkg::InstrWidth-1:0]   req_instr_i,
  input  logic [ipu_pkg::DataWidth-1:0]    req_arga_i,
  input  logic [ipu_pkg::DataWidth-1:0]    req_argb_i,
  // Decode
  input  ipu_pkg::alu_op_e                 alu_op_i,
  input  ipu_pkg::op_sel_e                 op_sel_a_i,
  input  ipu_pkg::op_sel_e                 op_sel_b_i,
  input  logic                             res_to_bus_i,
  input  logic                             writes_reg_i,
  input  logic                             illegal_i,
  // Register file
  input  logic [ipu_pkg::DataWidth-1:0]    rs_a_i,
  input  logic [ipu_pkg::DataWidth-1:0]    rs_b_i,
  output logic                             rf_we_o,
  output logic [ipu_pkg::RegAddrWidth-1:0] rf_waddr_o,
  output logic [ipu_pkg::DataWidth-1:0]    rf_wdata_o,
  // Response
  output logic                             resp_valid_o,
  input  logic                             resp_ready_i,
  output logic [ipu_pkg::IdWidth-1:0]      resp_id_o,
  output logic [ipu_pkg::DataWidth-1:0]    resp_data_o,
  output logic                             resp_error_o
);

  logic [ipu_pkg::DataWidth-1:0] imm;
  logic [ipu_pkg::DataWidth-1:0] opnd_a;
  logic [ipu_pkg::DataWidth-1:0] opnd_b;
  logic [ipu_pkg::DataWidth-1:0] alu_result;
  logic [4:0]                    shamt;
  logic                          accept;
  logic                          responds;
  logic                          resp_valid_q;

  function automatic logic [ipu_pkg::DataWidth-1:0] select_operand(
    input ipu_pkg::op_sel_e              sel,
    input logic [ipu_pkg::DataWidth-1:0] bus_val,
    input logic [ipu_pkg::DataWidth-1:0] imm_val,
    input logic [ipu_pkg::DataWidth-1:0] reg_val
  );
    case (sel)
      ipu_pkg::OpBus: return bus_val;
      ipu_pkg::OpImm: return imm_val;
      ipu_pkg::OpReg: return reg_val;
      default:        return '0;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Operands
  // --------------------------------------------------------------------------
  assign imm = {{(ipu_pkg::DataWidth - 12){req_instr_i[ipu_pkg::ImmMsb]}},
                req_instr_i[ipu_pkg::ImmMsb:ipu_pkg::ImmLsb]};

  assign opnd_a = select_operand(op_sel_a_i, req_arga_i, imm, rs_a_i);
  assign opnd_b = select_operand(op_sel_b_i, req_argb_i, imm, rs_b_i);
  assign shamt  = opnd_b[4:0];

  // --------------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------------
  always_comb begin
    case (alu_op_i)
      ipu_pkg::AluAdd:  alu_result = opnd_a + opnd_b;
      ipu_pkg::AluSub:  alu_result = opnd_a - opnd_b;
      ipu_pkg::AluSll:  alu_result = opnd_a << shamt;
      ipu_pkg::AluSrl:  alu_result = opnd_a >> shamt;
      ipu_pkg::AluSra:  alu_result = $unsigned($signed(opnd_a) >>> shamt);
      ipu_pkg::AluSlt:  alu_result = {31'd0, $signed(opnd_a) < $signed(opnd_b)};
      ipu_pkg::AluSltu: alu_result = {31'd0, opnd_a < opnd_b};
      ipu_pkg::AluAnd:  alu_result = opnd_a & opnd_b;
      ipu_pkg::AluOr:   alu_result = opnd_a | opnd_b;
      ipu_pkg::AluXor:  alu_result = opnd_a ^ opnd_b;
      ipu_pkg::AluAndn: alu_result = opnd_a & ~opnd_b;
      ipu_pkg::AluOrn:  alu_result = opnd_a | ~opnd_b;
      ipu_pkg::AluXnor: alu_result = ~(opnd_a ^ opnd_b);
      ipu_pkg::AluMin:  alu_result = ($signed(opnd_a) < $signed(opnd_b)) ? opnd_a : opnd_b;
      ipu_pkg::AluMax:  alu_result = ($signed(opnd_a) < $signed(opnd_b)) ? opnd_b : opnd_a;
      ipu_pkg::AluMinu: alu_result = (opnd_a < opnd_b) ? opnd_a : opnd_b;
      ipu_pkg::AluMaxu: alu_result = (opnd_a < opnd_b) ? opnd_b : opnd_a;
      default:          alu_result = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Handshake and write-back
  // --------------------------------------------------------------------------
  // Register writes wait for an empty response slot to keep program order
  assign req_ready_o = ~resp_valid_q | (resp_ready_i & ~writes_reg_i);
  assign accept      = req_valid_i & req_ready_o;
  assign responds    = res_to_bus_i | illegal_i;

  assign rf_we_o    = accept & writes_reg_i;
  assign rf_waddr_o = req_instr_i[ipu_pkg::RdMsb:ipu_pkg::RdLsb];
  assign rf_wdata_o = alu_result;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept && responds) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Payload only moves when a new response is taken in
  always_ff @(posedge clk_i) begin
    if (accept && responds) begin
      resp_id_o    <= req_id_i;
      resp_data_o  <= illegal_i ? '0 : alu_result;
      resp_error_o <= illegal_i;
    end
  end

  assign resp_valid_o = resp_valid_q;

endmodule

/* hw/ipu_regfile.sv */
// Integer register file, two asynchronous read ports and one write port.
// Register 0 holds data like any other register.

`timescale 1ns/1ps

module ipu_regfile (
  input  logic                             clk_i,
  input  logic [ipu_pkg::RegAddrWidth-1:0] raddr_a_i,
  input  logic [ipu_pkg::RegAddrWidth-1:0] raddr_b_i,
  output logic [ipu_pkg::DataWidth-1:0]    rdata_a_o,
  output logic [ipu_pkg::DataWidth-1:0]    rdata_b_o,
  input  logic                             we_i,
  input  logic [ipu_pkg::RegAddrWidth-1:0] waddr_i,
  input  logic [ipu_pkg::DataWidth-1:0]    wdata_i
);

  logic [ipu_pkg::DataWidth-1:0] regs_q [ipu_pkg::NumRegs];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see the old value during a write cycle
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* hw/ipu_decoder.sv */
// Combinational decoder of offloaded instruction words.
// Picks the ALU operation, operand sources and where the result goes.

`timescale 1ns/1ps

module ipu_decoder (
  input  logic [ipu_pkg::InstrWidth-1:0] instr_i,
  output ipu_pkg::alu_op_e               alu_op_o,
  output ipu_pkg::op_sel_e               op_sel_a_o,
  output ipu_pkg::op_sel_e               op_sel_b_o,
  output logic                           res_to_bus_o,
  output logic                           writes_reg_o,
  output logic                           illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;
  logic       alt_allowed;

  assign opcode = instr_i[ipu_pkg::OpcodeMsb:ipu_pkg::OpcodeLsb];
  assign funct3 = instr_i[ipu_pkg::Funct3Msb:ipu_pkg::Funct3Lsb];
  assign funct7 = instr_i[ipu_pkg::Funct7Msb:ipu_pkg::Funct7Lsb];

  assign f7_base = (funct7 == ipu_pkg::F7Base);
  assign f7_alt  = (funct7 == ipu_pkg::F7Alt);
  // Only sub and sra use the alternate funct7
  assign alt_allowed = f7_alt &&
                       (funct3 == ipu_pkg::F3AddSub || funct3 == ipu_pkg::F3SrlSra);

  always_comb begin
    alu_op_o     = ipu_pkg::AluAdd;
    op_sel_a_o   = ipu_pkg::OpNone;
    op_sel_b_o   = ipu_pkg::OpNone;
    res_to_bus_o = 1'b0;
    writes_reg_o = 1'b0;
    illegal_o    = 1'b0;

    case (opcode)
      ipu_pkg::OpcIpuReg: begin
        op_sel_a_o   = ipu_pkg::OpReg;
        op_sel_b_o   = ipu_pkg::OpReg;
        writes_reg_o = 1'b1;
        case (funct3)
          ipu_pkg::F3AddSub: alu_op_o = f7_alt ? ipu_pkg::AluSub : ipu_pkg::AluAdd;
          ipu_pkg::F3Sll:    alu_op_o = ipu_pkg::AluSll;
          ipu_pkg::F3Slt:    alu_op_o = ipu_pkg::AluSlt;
          ipu_pkg::F3Sltu:   alu_op_o = ipu_pkg::AluSltu;
          ipu_pkg::F3Xor:    alu_op_o = ipu_pkg::AluXor;
          ipu_pkg::F3SrlSra: alu_op_o = f7_alt ? ipu_pkg::AluSra : ipu_pkg::AluSrl;
          ipu_pkg::F3Or:     alu_op_o = ipu_pkg::AluOr;
          default:           alu_op_o = ipu_pkg::AluAnd;
        endcase
        illegal_o = !(f7_base || alt_allowed);
      end

      ipu_pkg::OpcIpuImm: begin
        op_sel_a_o   = ipu_pkg::OpReg;
        op_sel_b_o   = ipu_pkg::OpImm;
        writes_reg_o = 1'b1;
        case (funct3)
          ipu_pkg::F3AddSub: alu_op_o = ipu_pkg::AluAdd;
          ipu_pkg::F3Sll: begin
            alu_op_o  = ipu_pkg::AluSll;
            illegal_o = !f7_base;
          end
          ipu_pkg::F3Slt:    alu_op_o = ipu_pkg::AluSlt;
          ipu_pkg::F3Sltu:   alu_op_o = ipu_pkg::AluSltu;
          ipu_pkg::F3Xor:    alu_op_o = ipu_pkg::AluXor;
          ipu_pkg::F3SrlSra: begin
            alu_op_o  = f7_alt ? ipu_pkg::AluSra : ipu_pkg::AluSrl;
            illegal_o = !(f7_base || f7_alt);
          end
          ipu_pkg::F3Or:     alu_op_o = ipu_pkg::AluOr;
          default:           alu_op_o = ipu_pkg::AluAnd;
        endcase
      end

      // Moves pass operand a through an OR with zero
      ipu_pkg::OpcIpuMove: begin
        alu_op_o = ipu_pkg::AluOr;
        if (funct3 == ipu_pkg::F3ImvXW) begin
          op_sel_a_o   = ipu_pkg::OpReg;
          res_to_bus_o = 1'b1;
        end else if (funct3 == ipu_pkg::F3ImvWX) begin
          op_sel_a_o   = ipu_pkg::OpBus;
          writes_reg_o = 1'b1;
        end else begin
          illegal_o = 1'b1;
        end
      end

      ipu_pkg::OpcOp: begin
        op_sel_a_o   = ipu_pkg::OpBus;
        op_sel_b_o   = ipu_pkg::OpBus;
        res_to_bus_o = 1'b1;
        if (f7_alt && funct3 == ipu_pkg::F3And) alu_op_o = ipu_pkg::AluAndn;
        else if (f7_alt && funct3 == ipu_pkg::F3Or) alu_op_o = ipu_pkg::AluOrn;
        else if (f7_alt && funct3 == ipu_pkg::F3Xor) alu_op_o = ipu_pkg::AluXnor;
        else if (funct7 == ipu_pkg::F7MinMax && funct3[2]) begin
          case (funct3[1:0])
            2'b00:   alu_op_o = ipu_pkg::AluMin;
            2'b01:   alu_op_o = ipu_pkg::AluMinu;
            2'b10:   alu_op_o = ipu_pkg::AluMax;
            default: alu_op_o = ipu_pkg::AluMaxu;
          endcase
        end else begin
          illegal_o = 1'b1;
        end
      end

      default: illegal_o = 1'b1;
    endcase

    // Illegal words neither write nor take the normal result path
    if (illegal_o) begin
      res_to_bus_o = 1'b0;
      writes_reg_o = 1'b0;
    end
  end

endmodule

/* hw/ipu_pkg.sv */
// Shared widths, instruction encodings and enums of the integer subsystem.
// Modules refer to these by scoped name.

package ipu_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned InstrWidth   = 32;
  localparam int unsigned NumRegs      = 32;
  localparam int unsigned RegAddrWidth = $clog2(NumRegs);
  localparam int unsigned IdWidth      = 5;

  // --------------------------------------------------------------------------
  // Major opcodes
  // --------------------------------------------------------------------------
  // Custom-0, register-register
  localparam logic [6:0] OpcIpuReg  = 7'b0001011;
  // Custom-1, register-immediate
  localparam logic [6:0] OpcIpuImm  = 7'b0101011;
  // Custom-2, moves between core and subsystem
  localparam logic [6:0] OpcIpuMove = 7'b1011011;
  // Standard OP, used for the bus bit-manipulation group
  localparam logic [6:0] OpcOp      = 7'b0110011;

  // Instruction field positions
  localparam int unsigned OpcodeLsb = 0;
  localparam int unsigned OpcodeMsb = 6;
  localparam int unsigned RdLsb     = 7;
  localparam int unsigned RdMsb     = 11;
  localparam int unsigned Funct3Lsb = 12;
  localparam int unsigned Funct3Msb = 14;
  localparam int unsigned Rs1Lsb    = 15;
  localparam int unsigned Rs1Msb    = 19;
  localparam int unsigned Rs2Lsb    = 20;
  localparam int unsigned Rs2Msb    = 24;
  localparam int unsigned Funct7Lsb = 25;
  localparam int unsigned Funct7Msb = 31;
  localparam int unsigned ImmLsb    = 20;
  localparam int unsigned ImmMsb    = 31;

  // Funct3 values, RV32I meaning
  localparam logic [2:0] F3AddSub = 3'b000;
  localparam logic [2:0] F3Sll    = 3'b001;
  localparam logic [2:0] F3Slt    = 3'b010;
  localparam logic [2:0] F3Sltu   = 3'b011;
  localparam logic [2:0] F3Xor    = 3'b100;
  localparam logic [2:0] F3SrlSra = 3'b101;
  localparam logic [2:0] F3Or     = 3'b110;
  localparam logic [2:0] F3And    = 3'b111;

  // Move direction
  localparam logic [2:0] F3ImvXW  = 3'b000;
  localparam logic [2:0] F3ImvWX  = 3'b001;

  // Funct7 groups
  localparam logic [6:0] F7Base   = 7'b0000000;
  localparam logic [6:0] F7Alt    = 7'b0100000;
  localparam logic [6:0] F7MinMax = 7'b0000101;

  // --------------------------------------------------------------------------
  // Enums
  // --------------------------------------------------------------------------
  typedef enum logic [4:0] {
    AluAdd, AluSub, AluSll, AluSrl, AluSra, AluSlt, AluSltu,
    AluAnd, AluOr, AluXor, AluAndn, AluOrn, AluXnor,
    AluMin, AluMax, AluMinu, AluMaxu
  } alu_op_e;

  typedef enum logic [1:0] {
    OpNone,
    OpBus,
    OpImm,
    OpReg
  } op_sel_e;

endpackage
